// ==== src/wdt_pkg.sv ====
package wdt_pkg;

  // Counter and period width unless the top level overrides it
  parameter int CNT_W_DEFAULT = 32;

  // Timer 2 mode bit as held in the CTRL register
  parameter logic MODE_CASCADE     = 1'b0;
  parameter logic MODE_INDEPENDENT = 1'b1;

endpackage

// ==== src/wdt_reg_pkg.sv ====
package wdt_reg_pkg;

  parameter int ADDR_W = 5;
  parameter int DATA_W = 32;

  // Register map in byte addresses
  parameter logic [ADDR_W-1:0] ADDR_CTRL      = 5'h00;
  parameter logic [ADDR_W-1:0] ADDR_RESTART   = 5'h04;
  parameter logic [ADDR_W-1:0] ADDR_STATUS    = 5'h08;
  parameter logic [ADDR_W-1:0] ADDR_T1_PERIOD = 5'h0C;
  parameter logic [ADDR_W-1:0] ADDR_T2_PERIOD = 5'h10;

  // CTRL layout
  typedef struct packed {
    logic [DATA_W-3:0] rsvd;
    logic              t2_independent;
    logic              t1_en;
  } reg_ctrl_t;

  // One bit per timer for RESTART and for STATUS (write 1 to clear)
  typedef struct packed {
    logic [DATA_W-3:0] rsvd;
    logic              t2;
    logic              t1;
  } reg_pair_t;

  typedef union packed {
    reg_ctrl_t ctrl;
    reg_pair_t pair;
  } reg_word_u;

endpackage

// ==== src/wdt_ctrl_if.sv ====
`timescale 1ns/10ps

interface wdt_ctrl_if #(
  parameter int CNT_W = wdt_pkg::CNT_W_DEFAULT
);

  // Levels from the register block
  logic             t1_en;
  logic             t2_independent;
  logic [CNT_W-1:0] t1_period;
  logic [CNT_W-1:0] t2_period;

  // Single-cycle pulses decoded from a register write
  logic             t1_restart;
  logic             t2_restart;
  logic             t1_service;
  logic             t2_service;

  // Sticky expiry flags from the timers
  logic             t1_expired;
  logic             t2_expired;

  modport regs (
    output t1_en, t2_independent, t1_period, t2_period,
    output t1_restart, t2_restart, t1_service, t2_service,
    input  t1_expired, t2_expired
  );

  modport core (
    input  t1_en, t2_independent, t1_period, t2_period,
    input  t1_restart, t2_restart, t1_service, t2_service,
    output t1_expired, t2_expired
  );

endinterface

// ==== src/wdt_timer.sv ====
`timescale 1ns/10ps

module wdt_timer #(
  parameter int CNT_W = wdt_pkg::CNT_W_DEFAULT
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             count_en_i,
  input  logic             restart_i,
  input  logic             clear_count_i,
  input  logic             service_i,
  input  logic [CNT_W-1:0] period_i,
  output logic             expired_o
);

  logic [CNT_W-1:0] count_q;
  logic             expired_q;
  logic             at_period;

  assign at_period = (count_q == period_i);
  assign expired_o = expired_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else if (service_i) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else if (!expired_q) begin
      // Pet or cascade clear wins over a pending expiry
      if (restart_i || clear_count_i) begin
        count_q <= '0;
      end else if (at_period) begin
        expired_q <= 1'b1;
      end else if (count_en_i) begin
        count_q <= count_q + 1'b1;
      end
    end
    // Expired timer holds its count until serviced
  end

  restart_clears_count: assert property (
    @(posedge clk_i) disable iff (reset_i)
    restart_i && !expired_q |=> count_q == '0
  ) else $error("wdt_timer: restart did not clear the count");

endmodule

// ==== src/wdt_core.sv ====
`timescale 1ns/10ps

module wdt_core #(
  parameter int CNT_W = wdt_pkg::CNT_W_DEFAULT
) (
  input  logic       clk_i,
  input  logic       reset_i,
  wdt_ctrl_if.core   ctrl
);

  logic t2_count_en;
  logic t2_clear_count;
  logic cascade_mode;

  assign cascade_mode = (ctrl.t2_independent == wdt_pkg::MODE_CASCADE);

  // In cascade mode timer 2 only runs while timer 1 sits expired
  assign t2_count_en = (ctrl.t2_independent == wdt_pkg::MODE_INDEPENDENT) ?
                       ctrl.t1_en : ctrl.t1_expired;

  // Servicing timer 1 in cascade also rewinds timer 2
  assign t2_clear_count = cascade_mode && ctrl.t1_service;

  wdt_timer #(
    .CNT_W (CNT_W)
  ) t1_timer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .count_en_i    (ctrl.t1_en),
    .restart_i     (ctrl.t1_restart),
    .clear_count_i (1'b0),
    .service_i     (ctrl.t1_service),
    .period_i      (ctrl.t1_period),
    .expired_o     (ctrl.t1_expired)
  );

  wdt_timer #(
    .CNT_W (CNT_W)
  ) t2_timer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .count_en_i    (t2_count_en),
    .restart_i     (ctrl.t2_restart),
    .clear_count_i (t2_clear_count),
    .service_i     (ctrl.t2_service),
    .period_i      (ctrl.t2_period),
    .expired_o     (ctrl.t2_expired)
  );

  // Timer 2 stays parked at zero until timer 1 has expired
  cascade_t2_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cascade_mode && !ctrl.t1_expired && (t2_timer.count_q == '0)
      |=> t2_timer.count_q == '0
  ) else $error("wdt_core: timer 2 counted in cascade mode before timer 1 expired");

endmodule

// ==== src/wdt_regs.sv ====
`timescale 1ns/10ps

module wdt_regs #(
  parameter int CNT_W = wdt_pkg::CNT_W_DEFAULT
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           reg_wr_i,
  input  logic                           reg_rd_i,
  input  logic [wdt_reg_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [wdt_reg_pkg::DATA_W-1:0] reg_wdata_i,
  output logic [wdt_reg_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                           wdt_irq_o,
  output logic                           wdt_fatal_o,
  wdt_ctrl_if.regs                       ctrl
);

  localparam int DW = wdt_reg_pkg::DATA_W;

  wdt_reg_pkg::reg_word_u wr_word;
  wdt_reg_pkg::reg_word_u rd_word;

  logic             wr_ctrl;
  logic             wr_restart;
  logic             wr_status;
  logic             wr_t1_period;
  logic             wr_t2_period;

  logic             t1_en_q;
  logic             t2_indep_q;
  logic [CNT_W-1:0] t1_period_q;
  logic [CNT_W-1:0] t2_period_q;
  logic             t1_status_q;
  logic             t2_status_q;
  logic             t1_exp_q;
  logic             t2_exp_q;
  logic [DW-1:0]    rdata_q;

  assign wr_word = reg_wdata_i;

  assign wr_ctrl      = reg_wr_i && (reg_addr_i == wdt_reg_pkg::ADDR_CTRL);
  assign wr_restart   = reg_wr_i && (reg_addr_i == wdt_reg_pkg::ADDR_RESTART);
  assign wr_status    = reg_wr_i && (reg_addr_i == wdt_reg_pkg::ADDR_STATUS);
  assign wr_t1_period = reg_wr_i && (reg_addr_i == wdt_reg_pkg::ADDR_T1_PERIOD);
  assign wr_t2_period = reg_wr_i && (reg_addr_i == wdt_reg_pkg::ADDR_T2_PERIOD);

  // Pulses to the core in the same cycle as the write
  assign ctrl.t1_restart = wr_restart && wr_word.pair.t1;
  assign ctrl.t2_restart = wr_restart && wr_word.pair.t2;
  assign ctrl.t1_service = wr_status && wr_word.pair.t1;
  assign ctrl.t2_service = wr_status && wr_word.pair.t2;

  assign ctrl.t1_en          = t1_en_q;
  assign ctrl.t2_independent = t2_indep_q;
  assign ctrl.t1_period      = t1_period_q;
  assign ctrl.t2_period      = t2_period_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      t1_en_q     <= 1'b0;
      t2_indep_q  <= 1'b0;
      t1_period_q <= '1;
      t2_period_q <= '1;
    end else begin
      if (wr_ctrl) begin
        t1_en_q    <= wr_word.ctrl.t1_en;
        t2_indep_q <= wr_word.ctrl.t2_independent;
      end
      if (wr_t1_period) begin
        t1_period_q <= CNT_W'(reg_wdata_i);
      end
      if (wr_t2_period) begin
        t2_period_q <= CNT_W'(reg_wdata_i);
      end
    end
  end

  // Sticky status set on the expiry edge
  // A new timeout beats a clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      t1_exp_q    <= 1'b0;
      t2_exp_q    <= 1'b0;
      t1_status_q <= 1'b0;
      t2_status_q <= 1'b0;
    end else begin
      t1_exp_q <= ctrl.t1_expired;
      t2_exp_q <= ctrl.t2_expired;
      if (ctrl.t1_expired && !t1_exp_q) begin
        t1_status_q <= 1'b1;
      end else if (ctrl.t1_service) begin
        t1_status_q <= 1'b0;
      end
      if (ctrl.t2_expired && !t2_exp_q) begin
        t2_status_q <= 1'b1;
      end else if (ctrl.t2_service) begin
        t2_status_q <= 1'b0;
      end
    end
  end

  assign wdt_irq_o   = t1_status_q;
  assign wdt_fatal_o = t2_status_q;

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      wdt_reg_pkg::ADDR_CTRL: begin
        rd_word.ctrl.t1_en          = t1_en_q;
        rd_word.ctrl.t2_independent = t2_indep_q;
      end
      wdt_reg_pkg::ADDR_STATUS: begin
        rd_word.pair.t1 = t1_status_q;
        rd_word.pair.t2 = t2_status_q;
      end
      wdt_reg_pkg::ADDR_T1_PERIOD: rd_word = DW'(t1_period_q);
      wdt_reg_pkg::ADDR_T2_PERIOD: rd_word = DW'(t2_period_q);
      // RESTART reads back as zero
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (reg_rd_i) begin
      rdata_q <= rd_word;
    end
  end

  assign reg_rdata_o = rdata_q;

  t1_status_follows_expiry: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(ctrl.t1_expired) |=> t1_status_q
  ) else $error("wdt_regs: timer 1 status not set after expiry");

  t2_status_follows_expiry: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(ctrl.t2_expired) |=> t2_status_q
  ) else $error("wdt_regs: timer 2 status not set after expiry");

endmodule

// ==== src/wdt_top.sv ====
`timescale 1ns/10ps

module wdt_top #(
  parameter int CNT_W = wdt_pkg::CNT_W_DEFAULT
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           reg_wr_i,
  input  logic                           reg_rd_i,
  input  logic [wdt_reg_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [wdt_reg_pkg::DATA_W-1:0] reg_wdata_i,
  output logic [wdt_reg_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                           wdt_irq_o,
  output logic                           wdt_fatal_o
);

  // Control and status between register block and timers
  wdt_ctrl_if #(
    .CNT_W (CNT_W)
  ) ctrl_if ();

  wdt_regs #(
    .CNT_W (CNT_W)
  ) regs_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_wr_i    (reg_wr_i),
    .reg_rd_i    (reg_rd_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .wdt_irq_o   (wdt_irq_o),
    .wdt_fatal_o (wdt_fatal_o),
    .ctrl        (ctrl_if.regs)
  );

  wdt_core #(
    .CNT_W (CNT_W)
  ) core_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl    (ctrl_if.core)
  );

endmodule

// ==== bench/wdt_tb.sv ====
`timescale 1ns/10ps

module wdt_tb;

  localparam int DW = wdt_reg_pkg::DATA_W;
  localparam int AW = wdt_reg_pkg::ADDR_W;
  localparam int MAX_WORDS = 256;
  localparam int RESET_CYCLES = 16;

  // Golden file commands with four words per vector
  localparam int CMD_END        = 0;
  localparam int CMD_WRITE      = 1;
  localparam int CMD_READ       = 2;
  localparam int CMD_WAIT_IRQ   = 3;
  localparam int CMD_WAIT_FATAL = 4;
  localparam int CMD_CHECK_LOW  = 5;
  localparam int CMD_IDLE       = 6;

  logic          clk_i = 1'b0;
  logic          reset_i;
  logic          reg_wr_i;
  logic          reg_rd_i;
  logic [AW-1:0] reg_addr_i;
  logic [DW-1:0] reg_wdata_i;
  logic [DW-1:0] reg_rdata_o;
  logic          wdt_irq_o;
  logic          wdt_fatal_o;

  logic [31:0] vec_mem [0:MAX_WORDS-1];
  int          error_count;
  int          timeout_count;
  int          check_count;

  wdt_top #(
    .CNT_W (wdt_pkg::CNT_W_DEFAULT)
  ) wdt_top_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_wr_i    (reg_wr_i),
    .reg_rd_i    (reg_rd_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .wdt_irq_o   (wdt_irq_o),
    .wdt_fatal_o (wdt_fatal_o)
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // All bus tasks start and end on a falling edge
  task automatic write_reg(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_wr_i = 1'b0;
  endtask

  task automatic read_reg(input logic [AW-1:0] addr, input logic [DW-1:0] expected);
    reg_rd_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_rd_i = 1'b0;
    check_value($sformatf("reg_rdata_o at %h", addr), expected, reg_rdata_o);
  endtask

  // Counts falling edges until the output is high
  // Zero expected cycles accepts any count
  task automatic wait_for_rise(input logic use_fatal, input int expected_cycles,
                               input int bound);
    int    cycles;
    string name;
    logic  level;
    cycles = 0;
    name   = use_fatal ? "wdt_fatal_o" : "wdt_irq_o";
    level  = use_fatal ? wdt_fatal_o : wdt_irq_o;
    while (!level && cycles < bound) begin
      @(negedge clk_i);
      cycles++;
      level = use_fatal ? wdt_fatal_o : wdt_irq_o;
    end
    if (!level) begin
      timeout_count++;
      $display("Timeout at %0t: %s did not rise within %0d cycles", $time, name, bound);
    end else if (expected_cycles != 0) begin
      check_value({name, " rise cycles"}, expected_cycles, cycles);
    end
  endtask

  task automatic check_outputs_low(input logic [1:0] mask);
    if (mask[0]) begin
      check_value("wdt_irq_o", '0, DW'(wdt_irq_o));
    end
    if (mask[1]) begin
      check_value("wdt_fatal_o", '0, DW'(wdt_fatal_o));
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  initial begin : run_vectors
    int   idx;
    int   cmd;
    logic done;
    reset_i       = 1'b1;
    reg_wr_i      = 1'b0;
    reg_rd_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    error_count   = 0;
    timeout_count = 0;
    check_count   = 0;
    idx           = 0;
    done          = 1'b0;
    $readmemh("bench/wdt_golden.txt", vec_mem);
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    while (!done && idx + 3 < MAX_WORDS) begin
      cmd = int'(vec_mem[idx]);
      case (cmd)
        CMD_WRITE:      write_reg(AW'(vec_mem[idx+1]), vec_mem[idx+2]);
        CMD_READ:       read_reg(AW'(vec_mem[idx+1]), vec_mem[idx+3]);
        CMD_WAIT_IRQ:   wait_for_rise(1'b0, int'(vec_mem[idx+2]), int'(vec_mem[idx+3]));
        CMD_WAIT_FATAL: wait_for_rise(1'b1, int'(vec_mem[idx+2]), int'(vec_mem[idx+3]));
        CMD_CHECK_LOW:  check_outputs_low(vec_mem[idx+2][1:0]);
        CMD_IDLE:       idle_cycles(int'(vec_mem[idx+2]));
        CMD_END:        done = 1'b1;
        default: begin
          error_count++;
          $display("Unknown command %h in golden vector %0d", vec_mem[idx], idx / 4);
          done = 1'b1;
        end
      endcase
      idx += 4;
    end
    if (!done) begin
      error_count++;
      $display("Golden file ran past the vector memory without an end command");
    end
    if (check_count == 0) begin
      error_count++;
      $display("No value was checked because the golden file gave no usable vectors");
    end

    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== bench/wdt_golden.txt ====
// cmd addr data expect_or_bound, all hex
// 1 write, 2 read, 3 wait irq, 4 wait fatal (data = cycles, last = bound), 5 low mask, 6 idle, 0 end
2 00 00000000 00000000
2 08 00000000 00000000
2 0c 00000000 ffffffff
2 10 00000000 ffffffff
5 00 00000003 00000000
// Cascade expiry, P1 = 10, P2 = 6
1 0c 0000000a 00000000
1 10 00000006 00000000
1 00 00000001 00000000
1 04 00000001 00000000
3 00 0000000c 00000040
4 00 00000007 00000040
2 08 00000000 00000003
1 08 00000003 00000000
5 00 00000003 00000000
2 08 00000000 00000000
// Pet every five cycles
1 04 00000001 00000000
6 00 00000004 00000000
1 04 00000001 00000000
6 00 00000004 00000000
1 04 00000001 00000000
6 00 00000004 00000000
1 04 00000001 00000000
6 00 00000004 00000000
5 00 00000003 00000000
// Service and fresh expiry
3 00 00000000 00000040
1 08 00000001 00000000
5 00 00000003 00000000
3 00 0000000c 00000040
2 08 00000000 00000001
// Restart while expired
1 04 00000001 00000000
2 08 00000000 00000001
1 08 00000003 00000000
5 00 00000003 00000000
// Independent mode
1 00 00000003 00000000
1 04 00000003 00000000
4 00 00000008 00000040
5 00 00000001 00000000
3 00 00000004 00000040
2 08 00000000 00000003
0 00 00000000 00000000

// ==== verilog.f ====
src/wdt_pkg.sv
src/wdt_reg_pkg.sv
src/wdt_ctrl_if.sv
src/wdt_timer.sv
src/wdt_core.sv
src/wdt_regs.sv
src/wdt_top.sv
bench/wdt_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := wdt_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
	  ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "Result: FAIL"; exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
